// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_compliance_sys
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bus/mem_bus.sv ====
/* Fixed-priority bus where host 0 has the highest priority. Devices must answer
   exactly one cycle after their req; unmapped addresses get an error response. */

`default_nettype none

module mem_bus import mem_bus_pkg::*; #(
  parameter int unsigned NrHosts   = 3,
  parameter int unsigned NrDevices = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     host_req_i      [NrHosts],
  input  bus_req_t host_req_data_i [NrHosts],
  output logic     host_gnt_o      [NrHosts],
  output bus_rsp_t host_rsp_o      [NrHosts],

  output logic     dev_req_o       [NrDevices],
  output bus_req_t dev_req_data_o  [NrDevices],
  input  bus_rsp_t dev_rsp_i       [NrDevices],

  input  addr_t    cfg_base_i      [NrDevices],
  input  addr_t    cfg_mask_i      [NrDevices]
);

  localparam int unsigned HostIdxW = (NrHosts > 1) ? $clog2(NrHosts) : 1;
  localparam int unsigned DevIdxW  = (NrDevices > 1) ? $clog2(NrDevices) : 1;

  typedef logic [HostIdxW-1:0] host_idx_t;
  typedef logic [DevIdxW-1:0]  dev_idx_t;

  logic      host_mapped [NrHosts];
  dev_idx_t  host_dev    [NrHosts];

  logic      win_valid;
  logic      win_mapped;
  host_idx_t win_idx;
  dev_idx_t  win_dev;

  logic [NrDevices-1:0] dev_rvalid_vec;

  // Routing info for the response one cycle later
  logic      rsp_valid_q;
  logic      rsp_unmapped_q;
  host_idx_t rsp_host_q;
  dev_idx_t  rsp_dev_q;

  // Base/mask decode per host where the lowest device index wins on overlap
  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_mapped[h] = 1'b0;
      host_dev[h]    = '0;
      for (int d = NrDevices - 1; d >= 0; d--) begin
        if ((host_req_data_i[h].addr & cfg_mask_i[d]) == cfg_base_i[d]) begin
          host_mapped[h] = 1'b1;
          host_dev[h]    = dev_idx_t'(d);
        end
      end
    end
  end

  // Mapped requests beat unmapped ones; an unmapped host only wins
  // when no mapped host requests this cycle
  always_comb begin
    win_valid  = 1'b0;
    win_mapped = 1'b0;
    win_idx    = '0;
    win_dev    = '0;
    for (int h = 0; h < NrHosts; h++) begin
      if (host_req_i[h] && host_mapped[h] && !(win_valid && win_mapped)) begin
        win_valid  = 1'b1;
        win_mapped = 1'b1;
        win_idx    = host_idx_t'(h);
        win_dev    = host_dev[h];
      end else if (host_req_i[h] && !win_valid) begin
        win_valid  = 1'b1;
        win_mapped = 1'b0;
        win_idx    = host_idx_t'(h);
        win_dev    = '0;
      end
    end
  end

  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_gnt_o[h] = win_valid && (win_idx == host_idx_t'(h));
    end
  end

  // Only the selected device sees req while every device gets the payload
  always_comb begin
    for (int d = 0; d < NrDevices; d++) begin
      dev_req_o[d]      = win_valid && win_mapped && (win_dev == dev_idx_t'(d));
      dev_req_data_o[d] = host_req_data_i[win_idx];
      dev_rvalid_vec[d] = dev_rsp_i[d].rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q    <= 1'b0;
      rsp_unmapped_q <= 1'b0;
      rsp_host_q     <= '0;
      rsp_dev_q      <= '0;
    end else begin
      rsp_valid_q    <= win_valid;
      rsp_unmapped_q <= !win_mapped;
      rsp_host_q     <= win_idx;
      rsp_dev_q      <= win_dev;
    end
  end

  // Steer the device response back or answer unmapped accesses here
  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_rsp_o[h] = '0;
      if (rsp_valid_q && (rsp_host_q == host_idx_t'(h))) begin
        if (rsp_unmapped_q) begin
          host_rsp_o[h] = '{rvalid: 1'b1, rdata: '0, err: 1'b1};
        end else begin
          host_rsp_o[h] = dev_rsp_i[rsp_dev_q];
        end
      end
    end
  end

  // Devices answer one at a time and exactly one cycle after their req
  a_one_dev_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(dev_rvalid_vec));

  a_dev_rsp_in_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_valid_q && !rsp_unmapped_q) |-> dev_rsp_i[rsp_dev_q].rvalid);

endmodule

`default_nettype wire

// ==== common/mem_bus_pkg.sv ====
/* Shared bus types, index constants and the test utility register map.
   Byte addresses everywhere, and one request per host in flight at a time. */

`default_nettype none

package mem_bus_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  char_t;

  // Offset inside the 1 kB test utility window
  typedef logic [9:0]  tu_off_t;

  // Request payload, qualified by a separate req strobe
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // Response, one cycle after the request is accepted
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  localparam int unsigned NrHosts   = 3;
  localparam int unsigned NrDevices = 2;

  // Host indices, lowest index wins arbitration
  localparam int unsigned HostTestUtil = 0;
  localparam int unsigned HostCoreI    = 1;
  localparam int unsigned HostCoreD    = 2;

  // Device indices
  localparam int unsigned DevRam      = 0;
  localparam int unsigned DevTestUtil = 1;

  // Test utility window is fixed at 1 kB
  localparam addr_t TestUtilMask = ~addr_t'(32'h3FF);

  // Test utility register offsets
  localparam tu_off_t RegHalt      = 10'h000;
  localparam tu_off_t RegChar      = 10'h004;
  localparam tu_off_t RegDumpStart = 10'h008;
  localparam tu_off_t RegDumpEnd   = 10'h00C;
  localparam tu_off_t RegDumpGo    = 10'h010;

endpackage

`default_nettype wire

// ==== src.f ====
common/mem_bus_pkg.sv
bus/mem_bus.sv
verilog/ram_1p.sv
testutil/test_util.sv
verilog/compliance_sys.sv
tests/tb_compliance_sys.sv

// ==== tests/tb_compliance_sys.sv ====
/* Directed testbench for compliance_sys with both external hosts driven here.
   Only RAM words written by the tests are modelled; RAM starts undefined. */

`default_nettype none

module tb_compliance_sys import mem_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RamWordsP    = 16384;
  localparam addr_t       TuBase       = 32'h0002_0000;
  localparam int          ClkPeriod    = 20;
  localparam int          ResetCycles  = 10;
  localparam int          RamTestWords = 8;
  localparam int          DumpWords    = 8;
  localparam addr_t       RamTestBase  = 32'h0000_0040;
  localparam addr_t       DumpBase     = 32'h0000_0100;
  localparam int          GntTimeout   = 50;
  // Rough length of all tests at about four cycles per bus access
  localparam int TestCycles = ResetCycles + 2 + RamTestWords * 3 * 4 + 4 * 4 + 3 * 4
                              + 5 * 4 + (DumpWords + 4) * 4 + DumpWords * 4;
  localparam int WatchdogNs = (2 * TestCycles + 100) * ClkPeriod;

  logic     clk;
  logic     rst_n;
  logic     ext_req      [2];
  bus_req_t ext_req_data [2];
  logic     ext_gnt      [2];
  bus_rsp_t ext_rsp      [2];
  logic     halt;
  logic     char_valid;
  char_t    char_data;
  logic     sig_valid;
  data_t    sig_data;
  logic     dump_busy;

  int       errors = 0;
  int       checks = 0;
  int       char_count = 0;
  char_t    char_last;
  data_t    sig_q [$];
  data_t    ram_model [RamTestWords];

  compliance_sys #(
    .RamWords    (RamWordsP),
    .TestUtilBase(TuBase)
  ) dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .ext_req_i     (ext_req),
    .ext_req_data_i(ext_req_data),
    .ext_gnt_o     (ext_gnt),
    .ext_rsp_o     (ext_rsp),
    .halt_o        (halt),
    .char_valid_o  (char_valid),
    .char_data_o   (char_data),
    .sig_valid_o   (sig_valid),
    .sig_data_o    (sig_data),
    .dump_busy_o   (dump_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Output pulses collected away from the driving edge
  always @(negedge clk) begin
    if (rst_n && char_valid) begin
      char_count++;
      char_last = char_data;
    end
    if (rst_n && sig_valid) begin
      sig_q.push_back(sig_data);
    end
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is {%b, %h, %b}, expected {%b, %h, %b}", $time, name,
               got.rvalid, got.rdata, got.err, exp.rvalid, exp.rdata, exp.err);
    end
  endtask

  function automatic bus_req_t build_req(addr_t addr, logic we, be_t be, data_t wdata);
    bus_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic bus_rsp_t read_ok(data_t rdata);
    bus_rsp_t rsp;
    rsp.rvalid = 1'b1;
    rsp.rdata  = rdata;
    rsp.err    = 1'b0;
    return rsp;
  endfunction

  // New bytes replace old ones where be is set
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  task automatic await_grant(input int port);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!ext_gnt[port] && waited < GntTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (!ext_gnt[port]) begin
      errors++;
      $display("Error at %0d ns: port %0d not granted within %0d cycles", $time, port,
               GntTimeout);
    end
  endtask

  // Request is held until granted and answered in the next cycle
  task automatic issue_access(input int port, input bus_req_t req, output bus_rsp_t rsp);
    @(posedge clk);
    ext_req[port]      <= 1'b1;
    ext_req_data[port] <= req;
    await_grant(port);
    @(posedge clk);
    ext_req[port] <= 1'b0;
    @(negedge clk);
    rsp = ext_rsp[port];
    check_bit("ext_rsp_o.rvalid", rsp.rvalid, 1'b1);
  endtask

  task automatic store_word(input int port, input addr_t addr, input data_t wdata,
                            input be_t be);
    bus_rsp_t rsp;
    issue_access(port, build_req(addr, 1'b1, be, wdata), rsp);
    check_bit("ext_rsp_o.err", rsp.err, 1'b0);
  endtask

  task automatic fetch_word(input int port, input addr_t addr, output bus_rsp_t rsp);
    issue_access(port, build_req(addr, 1'b0, 4'hF, '0), rsp);
  endtask

  task automatic idle_outputs_check();
    for (int p = 0; p < 2; p++) begin
      check_bit("ext_gnt_o", ext_gnt[p], 1'b0);
      check_bit("ext_rsp_o.rvalid", ext_rsp[p].rvalid, 1'b0);
    end
    check_bit("halt_o", halt, 1'b0);
    check_bit("char_valid_o", char_valid, 1'b0);
    check_bit("sig_valid_o", sig_valid, 1'b0);
    check_bit("dump_busy_o", dump_busy, 1'b0);
  endtask

  task automatic reset_state_test();
    repeat (ResetCycles) begin
      @(negedge clk);
      idle_outputs_check();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    idle_outputs_check();
  endtask

  // Writes on the data port and reads back on the instruction port
  task automatic ram_access_test();
    bus_rsp_t rsp;
    data_t    wdata;
    be_t      be;
    addr_t    addr;
    for (int i = 0; i < RamTestWords; i++) begin
      addr  = RamTestBase + addr_t'(4 * i);
      wdata = $urandom();
      store_word(1, addr, wdata, 4'hF);
      ram_model[i] = wdata;
      wdata = $urandom();
      be    = be_t'($urandom_range(1, 14));
      store_word(1, addr, wdata, be);
      ram_model[i] = merge_bytes(ram_model[i], wdata, be);
    end
    for (int i = 0; i < RamTestWords; i++) begin
      fetch_word(0, RamTestBase + addr_t'(4 * i), rsp);
      check_rsp("ext_rsp_o[0]", rsp, read_ok(ram_model[i]));
    end
  endtask

  task automatic priority_test();
    @(posedge clk);
    ext_req[0]      <= 1'b1;
    ext_req_data[0] <= build_req(RamTestBase, 1'b0, 4'hF, '0);
    ext_req[1]      <= 1'b1;
    ext_req_data[1] <= build_req(RamTestBase + addr_t'(4), 1'b0, 4'hF, '0);
    @(negedge clk);
    check_bit("ext_gnt_o[0]", ext_gnt[0], 1'b1);
    check_bit("ext_gnt_o[1]", ext_gnt[1], 1'b0);
    @(posedge clk);
    ext_req[0] <= 1'b0;
    @(negedge clk);
    check_rsp("ext_rsp_o[0]", ext_rsp[0], read_ok(ram_model[0]));
    check_bit("ext_gnt_o[1]", ext_gnt[1], 1'b1);
    @(posedge clk);
    ext_req[1] <= 1'b0;
    @(negedge clk);
    check_rsp("ext_rsp_o[1]", ext_rsp[1], read_ok(ram_model[1]));
  endtask

  task automatic error_path_test();
    bus_rsp_t rsp;
    fetch_word(1, 32'h0010_0000, rsp);
    check_bit("ext_rsp_o[1].err", rsp.err, 1'b1);
    fetch_word(1, TuBase + addr_t'(32'h20), rsp);
    check_bit("ext_rsp_o[1].err", rsp.err, 1'b1);
    fetch_word(1, RamTestBase, rsp);
    check_rsp("ext_rsp_o[1]", rsp, read_ok(ram_model[0]));
  endtask

  task automatic control_reg_test();
    bus_rsp_t rsp;
    data_t    wdata;
    int       count_before;
    count_before = char_count;
    wdata = $urandom();
    store_word(1, TuBase + addr_t'(RegChar), wdata, 4'hF);
    repeat (3) @(posedge clk);
    check_data("char_valid_o pulses", data_t'(char_count - count_before), 32'd1);
    check_data("char_data_o", data_t'(char_last), data_t'(wdata[7:0]));
    check_bit("halt_o", halt, 1'b0);
    store_word(1, TuBase + addr_t'(RegHalt), 32'h1, 4'hF);
    check_bit("halt_o", halt, 1'b1);
    wdata = $urandom() & 32'hFFFF_FFFC;
    store_word(1, TuBase + addr_t'(RegDumpStart), wdata, 4'hF);
    fetch_word(1, TuBase + addr_t'(RegDumpStart), rsp);
    check_rsp("ext_rsp_o[1]", rsp, read_ok(wdata));
  endtask

  task automatic signature_dump_test();
    data_t preload [DumpWords];
    int    waited;
    for (int i = 0; i < DumpWords; i++) begin
      preload[i] = $urandom();
      store_word(1, DumpBase + addr_t'(4 * i), preload[i], 4'hF);
    end
    store_word(1, TuBase + addr_t'(RegDumpStart), DumpBase, 4'hF);
    store_word(1, TuBase + addr_t'(RegDumpEnd), DumpBase + addr_t'(4 * DumpWords), 4'hF);
    sig_q.delete();
    // Go on the instruction port with a data port read queued right behind it
    @(posedge clk);
    ext_req[0]      <= 1'b1;
    ext_req_data[0] <= build_req(TuBase + addr_t'(RegDumpGo), 1'b1, 4'hF, 32'h1);
    await_grant(0);
    @(posedge clk);
    ext_req[0]      <= 1'b0;
    ext_req[1]      <= 1'b1;
    ext_req_data[1] <= build_req(DumpBase, 1'b0, 4'hF, '0);
    @(negedge clk);
    check_bit("ext_rsp_o[0].rvalid", ext_rsp[0].rvalid, 1'b1);
    check_bit("dump_busy_o", dump_busy, 1'b1);
    check_bit("ext_gnt_o[1]", ext_gnt[1], 1'b0);
    await_grant(1);
    @(posedge clk);
    ext_req[1] <= 1'b0;
    @(negedge clk);
    check_rsp("ext_rsp_o[1]", ext_rsp[1], read_ok(preload[0]));
    waited = 0;
    while (dump_busy && waited < DumpWords * 4 + GntTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (dump_busy) begin
      errors++;
      $display("Error at %0d ns: dump_busy_o never fell", $time);
    end
    @(posedge clk);
    check_data("signature word count", data_t'(sig_q.size()), data_t'(DumpWords));
    for (int i = 0; i < DumpWords && i < sig_q.size(); i++) begin
      check_data($sformatf("sig_data_o[%0d]", i), sig_q[i], preload[i]);
    end
  endtask

  initial begin
    void'($urandom(43));
    rst_n = 1'b0;
    for (int p = 0; p < 2; p++) begin
      ext_req[p]      = 1'b0;
      ext_req_data[p] = '0;
    end
    reset_state_test();
    ram_access_test();
    priority_test();
    error_path_test();
    control_reg_test();
    signature_dump_test();
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Error: watchdog expired after %0d ns, a test is stuck", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testutil/test_util.sv ====
/* Halt, char-out and signature-dump registers. Register writes ignore byte
   enables; a dump go while a dump is running is dropped. */

`default_nettype none

module test_util import mem_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     dev_req_i,
  input  bus_req_t dev_req_data_i,
  output bus_rsp_t dev_rsp_o,

  output logic     host_req_o,
  output bus_req_t host_req_data_o,
  input  logic     host_gnt_i,
  input  bus_rsp_t host_rsp_i,

  output logic     halt_o,
  output logic     char_valid_o,
  output char_t    char_data_o,
  output logic     sig_valid_o,
  output data_t    sig_data_o,
  output logic     dump_busy_o
);

  typedef enum logic [1:0] {
    DumpIdle,
    DumpReq,
    DumpWait
  } dump_state_e;

  dump_state_e state_q, state_d;

  tu_off_t dev_off;
  logic    dev_wr;
  logic    dump_go;
  logic    dump_more;

  logic    halt_q;
  logic    char_valid_q;
  char_t   char_data_q;
  addr_t   dump_start_q;
  addr_t   dump_end_q;
  addr_t   dump_addr_q;

  logic    rsp_valid_q;
  logic    rsp_err_q;
  data_t   rsp_rdata_q;

  assign dev_off = dev_req_data_i.addr[9:0];
  assign dev_wr  = dev_req_i && dev_req_data_i.we;
  assign dump_go = dev_wr && (dev_off == RegDumpGo) && (state_q == DumpIdle);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      halt_q       <= 1'b0;
      char_valid_q <= 1'b0;
      dump_start_q <= '0;
      dump_end_q   <= '0;
    end else begin
      char_valid_q <= dev_wr && (dev_off == RegChar);
      if (dev_wr) begin
        case (dev_off)
          RegHalt:      halt_q       <= 1'b1;
          RegDumpStart: dump_start_q <= dev_req_data_i.wdata;
          RegDumpEnd:   dump_end_q   <= dev_req_data_i.wdata;
          default:      ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_wr && (dev_off == RegChar)) begin
      char_data_q <= dev_req_data_i.wdata[7:0];
    end
  end

  // Device response follows one cycle after req
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= dev_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i) begin
      rsp_err_q   <= 1'b0;
      rsp_rdata_q <= '0;
      case (dev_off)
        RegHalt:      rsp_rdata_q <= data_t'(halt_q);
        RegDumpStart: rsp_rdata_q <= dump_start_q;
        RegDumpEnd:   rsp_rdata_q <= dump_end_q;
        RegChar, RegDumpGo: ;
        default:      rsp_err_q <= 1'b1;
      endcase
    end
  end

  assign dev_rsp_o = '{rvalid: rsp_valid_q, rdata: rsp_rdata_q, err: rsp_err_q};

  // Dump engine keeps one read in flight at a time
  assign dump_more = dump_addr_q < dump_end_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DumpIdle: if (dump_go) state_d = DumpReq;
      DumpReq: begin
        if (!dump_more) begin
          state_d = DumpIdle;
        end else if (host_gnt_i) begin
          state_d = DumpWait;
        end
      end
      DumpWait: begin
        if (host_rsp_i.rvalid) begin
          state_d = dump_more ? DumpReq : DumpIdle;
        end
      end
      default: state_d = DumpIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= DumpIdle;
      dump_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (dump_go) begin
        dump_addr_q <= dump_start_q;
      end else if (host_req_o && host_gnt_i) begin
        dump_addr_q <= dump_addr_q + addr_t'(4);
      end
    end
  end

  assign host_req_o      = (state_q == DumpReq) && dump_more;
  assign host_req_data_o = '{addr: dump_addr_q, we: 1'b0, be: '1, wdata: '0};

  // Every read response while waiting is a signature word
  assign sig_valid_o  = (state_q == DumpWait) && host_rsp_i.rvalid;
  assign sig_data_o   = host_rsp_i.rdata;

  assign halt_o       = halt_q;
  assign char_valid_o = char_valid_q;
  assign char_data_o  = char_data_q;
  assign dump_busy_o  = (state_q != DumpIdle);

  // The bus only routes a response here for a read that is still outstanding
  a_rsp_only_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_i.rvalid |-> (state_q == DumpWait));

endmodule

`default_nettype wire

// ==== verilog/compliance_sys.sv ====
/* Bus system with RAM at 0 and the test utility at TestUtilBase.
   ext port 0 is the instruction host, ext port 1 the data host. */

`default_nettype none

module compliance_sys import mem_bus_pkg::*; #(
  parameter int unsigned RamWords     = 16384,
  parameter addr_t       TestUtilBase = 32'h0002_0000
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     ext_req_i      [2],
  input  bus_req_t ext_req_data_i [2],
  output logic     ext_gnt_o      [2],
  output bus_rsp_t ext_rsp_o      [2],

  output logic     halt_o,
  output logic     char_valid_o,
  output char_t    char_data_o,
  output logic     sig_valid_o,
  output data_t    sig_data_o,
  output logic     dump_busy_o
);

  logic     host_req      [NrHosts];
  bus_req_t host_req_data [NrHosts];
  logic     host_gnt      [NrHosts];
  bus_rsp_t host_rsp      [NrHosts];

  logic     dev_req       [NrDevices];
  bus_req_t dev_req_data  [NrDevices];
  bus_rsp_t dev_rsp       [NrDevices];

  addr_t    cfg_base      [NrDevices];
  addr_t    cfg_mask      [NrDevices];

  // Address map
  assign cfg_base[DevRam]      = '0;
  assign cfg_mask[DevRam]      = ~addr_t'(RamWords * 4 - 1);
  assign cfg_base[DevTestUtil] = TestUtilBase;
  assign cfg_mask[DevTestUtil] = TestUtilMask;

  // External hosts stand in for the core
  assign host_req[HostCoreI]      = ext_req_i[0];
  assign host_req_data[HostCoreI] = ext_req_data_i[0];
  assign host_req[HostCoreD]      = ext_req_i[1];
  assign host_req_data[HostCoreD] = ext_req_data_i[1];
  assign ext_gnt_o[0]             = host_gnt[HostCoreI];
  assign ext_gnt_o[1]             = host_gnt[HostCoreD];
  assign ext_rsp_o[0]             = host_rsp[HostCoreI];
  assign ext_rsp_o[1]             = host_rsp[HostCoreD];

  mem_bus #(
    .NrHosts  (NrHosts),
    .NrDevices(NrDevices)
  ) u_bus (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .host_req_i     (host_req),
    .host_req_data_i(host_req_data),
    .host_gnt_o     (host_gnt),
    .host_rsp_o     (host_rsp),
    .dev_req_o      (dev_req),
    .dev_req_data_o (dev_req_data),
    .dev_rsp_i      (dev_rsp),
    .cfg_base_i     (cfg_base),
    .cfg_mask_i     (cfg_mask)
  );

  ram_1p #(
    .Depth(RamWords)
  ) u_ram (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (dev_req[DevRam]),
    .req_data_i(dev_req_data[DevRam]),
    .rsp_o     (dev_rsp[DevRam])
  );

  test_util u_test_util (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dev_req_i      (dev_req[DevTestUtil]),
    .dev_req_data_i (dev_req_data[DevTestUtil]),
    .dev_rsp_o      (dev_rsp[DevTestUtil]),
    .host_req_o     (host_req[HostTestUtil]),
    .host_req_data_o(host_req_data[HostTestUtil]),
    .host_gnt_i     (host_gnt[HostTestUtil]),
    .host_rsp_i     (host_rsp[HostTestUtil]),
    .halt_o         (halt_o),
    .char_valid_o   (char_valid_o),
    .char_data_o    (char_data_o),
    .sig_valid_o    (sig_valid_o),
    .sig_data_o     (sig_data_o),
    .dump_busy_o    (dump_busy_o)
  );

endmodule

`default_nettype wire

// ==== verilog/ram_1p.sv ====
/* Word RAM with byte enables, read data one cycle after req.
   Depth must be a power of two; upper address bits wrap. */

`default_nettype none

module ram_1p import mem_bus_pkg::*; #(
  parameter int unsigned Depth = 16384
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IdxW = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [IdxW-1:0] word_idx_t;

  data_t     mem_q [Depth];
  word_idx_t word_idx;
  data_t     rdata_q;
  logic      rvalid_q;

  // Drop the byte offset
  assign word_idx = req_data_i.addr[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (req_data_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_data_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // Writes are acknowledged too
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire
